/* design/wbmem_consts.svh */
// Memory subsystem constants

`ifndef WBMEM_CONSTS_SVH
`define WBMEM_CONSTS_SVH

// wishbone data bus, 64 bits only
`define WB_DATA_WIDTH 64

// one select bit per byte lane
`define WB_SEL_WIDTH 8

// word address, byte offset bits are implied zero
`define WB_ADR_WIDTH 10

// storage depth in words
`define MEM_WORDS 1024

// one bit is enough for two bridges
`define SRC_ID_WIDTH 1

`endif

/* design/wbmem_pkg.sv */
// Memory message types

`include "wbmem_consts.svh"

package wbmem_pkg;

  typedef logic [`WB_DATA_WIDTH-1:0] wb_data_t;
  typedef logic [`WB_SEL_WIDTH-1:0]  wb_sel_t;
  typedef logic [`WB_ADR_WIDTH-1:0]  wb_adr_t;
  typedef logic [`SRC_ID_WIDTH-1:0]  src_id_t;

  typedef enum logic
  {
    e_uc_rd = 1'b0
    , e_uc_wr = 1'b1
  } msg_type_e;

  // log2 of the byte count
  typedef enum logic [1:0]
  {
    e_size_1 = 2'b00
    , e_size_2 = 2'b01
    , e_size_4 = 2'b10
    , e_size_8 = 2'b11
  } msg_size_e;

  typedef struct packed
  {
    msg_type_e msg_type;
    msg_size_e size;
    wb_adr_t   addr;
    src_id_t   src;
  } mem_fwd_header_s;

  typedef struct packed
  {
    msg_type_e msg_type;
    msg_size_e size;
    src_id_t   src;
  } mem_rev_header_s;

  typedef enum logic
  {
    e_idle = 1'b0
    , e_resp = 1'b1
  } ep_state_e;

  // copy the low 2^size bytes across the whole bus
  function automatic wb_data_t replicate_data(wb_data_t data, msg_size_e size);
    wb_data_t rep;
    case (size)
      e_size_1: rep = {8{data[7:0]}};
      e_size_2: rep = {4{data[15:0]}};
      e_size_4: rep = {2{data[31:0]}};
      default:  rep = data;
    endcase
    return rep;
  endfunction

endpackage

/* design/wb_client_bridge.sv */
// Wishbone client bridge

`timescale 1ns/1ps

module wb_client_bridge
  #(parameter wbmem_pkg::src_id_t src_id_p = '0)
  (input                                      clk_i
   , input                                    reset_i

   // wishbone client side
   , input wbmem_pkg::wb_adr_t                adr_i
   , input wbmem_pkg::wb_data_t               dat_i
   , input                                    cyc_i
   , input                                    stb_i
   , input wbmem_pkg::wb_sel_t                sel_i
   , input                                    we_i

   , output wbmem_pkg::wb_data_t              dat_o
   , output logic                             ack_o

   // forward message channel
   , output wbmem_pkg::mem_fwd_header_s       mem_fwd_header_o
   , output wbmem_pkg::wb_data_t              mem_fwd_data_o
   , output logic                             mem_fwd_v_o
   , input                                    mem_fwd_ready_and_i

   // reverse message channel
   , input wbmem_pkg::mem_rev_header_s        mem_rev_header_i
   , input wbmem_pkg::wb_data_t               mem_rev_data_i
   , input                                    mem_rev_v_i
   , output logic                             mem_rev_ready_and_o
   );

  logic                 pending_r;
  logic                 fwd_done;
  logic                 ack_n;
  wbmem_pkg::wb_data_t  dat_n;
  wbmem_pkg::msg_size_e msg_size;

  assign fwd_done = mem_fwd_v_o & mem_fwd_ready_and_i;

  // one access in flight, cleared by the ack pulse
  always_ff @(posedge clk_i)
    begin
      if (reset_i)
        pending_r <= 1'b0;
      else if (fwd_done)
        pending_r <= 1'b1;
      else if (ack_o)
        pending_r <= 1'b0;
    end

  assign mem_rev_ready_and_o = pending_r;
  assign mem_fwd_v_o = cyc_i & stb_i & ~pending_r;

  // reverse transfer turns into ack next cycle
  assign ack_n = mem_rev_ready_and_o & mem_rev_v_i;

  // write replies carry no data
  assign dat_n = (mem_rev_header_i.msg_type == wbmem_pkg::e_uc_rd)
                 ? mem_rev_data_i
                 : '0;

  always_ff @(posedge clk_i)
    begin
      if (reset_i)
        ack_o <= 1'b0;
      else
        ack_o <= ack_n;
    end

  always_ff @(posedge clk_i)
    begin
      if (ack_n)
        dat_o <= dat_n;
    end

  // size from byte select, anything odd is a full word
  always_comb
    begin
      case (sel_i)
        8'h01:   msg_size = wbmem_pkg::e_size_1;
        8'h03:   msg_size = wbmem_pkg::e_size_2;
        8'h0F:   msg_size = wbmem_pkg::e_size_4;
        default: msg_size = wbmem_pkg::e_size_8;
      endcase
    end

  always_comb
    begin
      mem_fwd_header_o.msg_type = we_i ? wbmem_pkg::e_uc_wr : wbmem_pkg::e_uc_rd;
      mem_fwd_header_o.size     = msg_size;
      mem_fwd_header_o.addr     = adr_i;
      mem_fwd_header_o.src      = src_id_p;
    end

  // small writes are replicated across the bus
  assign mem_fwd_data_o = wbmem_pkg::replicate_data(dat_i, msg_size);

endmodule

/* design/mem_fwd_arbiter.sv */
// Forward channel arbiter

`timescale 1ns/1ps

module mem_fwd_arbiter
  (input                                            clk_i
   , input                                          reset_i

   // bridge side
   , input wbmem_pkg::mem_fwd_header_s [1:0]        bridge_fwd_header_i
   , input wbmem_pkg::wb_data_t [1:0]               bridge_fwd_data_i
   , input [1:0]                                    bridge_fwd_v_i
   , output logic [1:0]                             bridge_fwd_ready_and_o

   , output wbmem_pkg::mem_rev_header_s [1:0]       bridge_rev_header_o
   , output wbmem_pkg::wb_data_t [1:0]              bridge_rev_data_o
   , output logic [1:0]                             bridge_rev_v_o
   , input [1:0]                                    bridge_rev_ready_and_i

   // memory side
   , output wbmem_pkg::mem_fwd_header_s             mem_fwd_header_o
   , output wbmem_pkg::wb_data_t                    mem_fwd_data_o
   , output logic                                   mem_fwd_v_o
   , input                                          mem_fwd_ready_and_i

   , input wbmem_pkg::mem_rev_header_s              mem_rev_header_i
   , input wbmem_pkg::wb_data_t                     mem_rev_data_i
   , input                                          mem_rev_v_i
   , output logic                                   mem_rev_ready_and_o
   );

  wbmem_pkg::src_id_t ptr_r;
  wbmem_pkg::src_id_t grant_id;
  wbmem_pkg::src_id_t rev_dst;
  logic               fwd_done;

  // pointer holds the bridge with priority
  always_comb
    begin
      if (bridge_fwd_v_i[ptr_r])
        grant_id = ptr_r;
      else
        grant_id = ~ptr_r;
    end

  assign mem_fwd_v_o = |bridge_fwd_v_i;
  assign fwd_done = mem_fwd_v_o & mem_fwd_ready_and_i;

  always_comb
    begin
      mem_fwd_header_o     = bridge_fwd_header_i[grant_id];
      mem_fwd_header_o.src = grant_id;
      mem_fwd_data_o       = bridge_fwd_data_i[grant_id];
    end

  // only the winner sees ready
  always_comb
    begin
      bridge_fwd_ready_and_o           = '0;
      bridge_fwd_ready_and_o[grant_id] = mem_fwd_ready_and_i;
    end

  // move past the winner once its message is taken
  always_ff @(posedge clk_i)
    begin
      if (reset_i)
        ptr_r <= '0;
      else if (fwd_done)
        ptr_r <= ~grant_id;
    end

  // replies go back by the stamped source
  assign rev_dst = mem_rev_header_i.src;

  always_comb
    begin
      for (int i = 0; i < 2; i++)
        begin
          bridge_rev_header_o[i] = mem_rev_header_i;
          bridge_rev_data_o[i]   = mem_rev_data_i;
          bridge_rev_v_o[i]      = mem_rev_v_i & (rev_dst == wbmem_pkg::src_id_t'(i));
        end
    end

  assign mem_rev_ready_and_o = bridge_rev_ready_and_i[rev_dst];

endmodule

/* design/uc_mem_endpoint.sv */
// Uncached memory endpoint

`timescale 1ns/1ps

`include "wbmem_consts.svh"

module uc_mem_endpoint
  (input                                      clk_i
   , input                                    reset_i

   // forward message channel
   , input wbmem_pkg::mem_fwd_header_s        mem_fwd_header_i
   , input wbmem_pkg::wb_data_t               mem_fwd_data_i
   , input                                    mem_fwd_v_i
   , output logic                             mem_fwd_ready_and_o

   // reverse message channel
   , output wbmem_pkg::mem_rev_header_s       mem_rev_header_o
   , output wbmem_pkg::wb_data_t              mem_rev_data_o
   , output logic                             mem_rev_v_o
   , input                                    mem_rev_ready_and_i
   );

  wbmem_pkg::ep_state_e       state_r;
  wbmem_pkg::ep_state_e       state_n;
  wbmem_pkg::wb_data_t        mem_r [`MEM_WORDS];
  wbmem_pkg::wb_data_t        rd_word;
  wbmem_pkg::wb_sel_t         wr_mask;
  wbmem_pkg::mem_rev_header_s rev_header_r;
  wbmem_pkg::wb_data_t        rev_data_r;
  logic                       fwd_accept;
  logic                       rev_done;
  logic                       is_write;

  assign mem_fwd_ready_and_o = (state_r == wbmem_pkg::e_idle);
  assign mem_rev_v_o         = (state_r == wbmem_pkg::e_resp);
  assign fwd_accept          = mem_fwd_v_i & mem_fwd_ready_and_o;
  assign rev_done            = mem_rev_v_o & mem_rev_ready_and_i;
  assign is_write            = (mem_fwd_header_i.msg_type == wbmem_pkg::e_uc_wr);

  always_comb
    begin
      state_n = state_r;
      case (state_r)
        wbmem_pkg::e_idle:
          if (fwd_accept)
            state_n = wbmem_pkg::e_resp;
        wbmem_pkg::e_resp:
          if (rev_done)
            state_n = wbmem_pkg::e_idle;
        default:
          state_n = wbmem_pkg::e_idle;
      endcase
    end

  always_ff @(posedge clk_i)
    begin
      if (reset_i)
        state_r <= wbmem_pkg::e_idle;
      else
        state_r <= state_n;
    end

  // low 2^size byte lanes
  always_comb
    begin
      case (mem_fwd_header_i.size)
        wbmem_pkg::e_size_1: wr_mask = 8'h01;
        wbmem_pkg::e_size_2: wr_mask = 8'h03;
        wbmem_pkg::e_size_4: wr_mask = 8'h0F;
        default:             wr_mask = 8'hFF;
      endcase
    end

  assign rd_word = mem_r[mem_fwd_header_i.addr];

  // byte-merged write
  always_ff @(posedge clk_i)
    begin
      if (fwd_accept & is_write)
        for (int i = 0; i < `WB_SEL_WIDTH; i++)
          begin
            if (wr_mask[i])
              mem_r[mem_fwd_header_i.addr][8*i+:8] <= mem_fwd_data_i[8*i+:8];
          end
    end

  // reply captured at accept, held under back-pressure
  always_ff @(posedge clk_i)
    begin
      if (fwd_accept)
        begin
          rev_header_r.msg_type <= mem_fwd_header_i.msg_type;
          rev_header_r.size     <= mem_fwd_header_i.size;
          rev_header_r.src      <= mem_fwd_header_i.src;
          rev_data_r            <= is_write
                                   ? '0
                                   : wbmem_pkg::replicate_data(rd_word, mem_fwd_header_i.size);
        end
    end

  assign mem_rev_header_o = rev_header_r;
  assign mem_rev_data_o   = rev_data_r;

endmodule

/* design/dual_wb_mem_top.sv */
// Dual Wishbone memory top

`timescale 1ns/1ps

module dual_wb_mem_top
  (input                                clk_i
   , input                              reset_i

   // wishbone port a
   , input wbmem_pkg::wb_adr_t          a_adr_i
   , input wbmem_pkg::wb_data_t         a_dat_i
   , input                              a_cyc_i
   , input                              a_stb_i
   , input wbmem_pkg::wb_sel_t          a_sel_i
   , input                              a_we_i
   , output wbmem_pkg::wb_data_t        a_dat_o
   , output logic                       a_ack_o

   // wishbone port b
   , input wbmem_pkg::wb_adr_t          b_adr_i
   , input wbmem_pkg::wb_data_t         b_dat_i
   , input                              b_cyc_i
   , input                              b_stb_i
   , input wbmem_pkg::wb_sel_t          b_sel_i
   , input                              b_we_i
   , output wbmem_pkg::wb_data_t        b_dat_o
   , output logic                       b_ack_o
   );

  // bridge to arbiter
  wbmem_pkg::mem_fwd_header_s [1:0] br_fwd_header;
  wbmem_pkg::wb_data_t [1:0]        br_fwd_data;
  logic [1:0]                       br_fwd_v;
  logic [1:0]                       br_fwd_ready_and;
  wbmem_pkg::mem_rev_header_s [1:0] br_rev_header;
  wbmem_pkg::wb_data_t [1:0]        br_rev_data;
  logic [1:0]                       br_rev_v;
  logic [1:0]                       br_rev_ready_and;

  // arbiter to endpoint
  wbmem_pkg::mem_fwd_header_s       mem_fwd_header;
  wbmem_pkg::wb_data_t              mem_fwd_data;
  logic                             mem_fwd_v;
  logic                             mem_fwd_ready_and;
  wbmem_pkg::mem_rev_header_s       mem_rev_header;
  wbmem_pkg::wb_data_t              mem_rev_data;
  logic                             mem_rev_v;
  logic                             mem_rev_ready_and;

  wb_client_bridge
   #(.src_id_p(1'b0))
   bridge_a
    (.clk_i(clk_i)
     ,.reset_i(reset_i)
     ,.adr_i(a_adr_i)
     ,.dat_i(a_dat_i)
     ,.cyc_i(a_cyc_i)
     ,.stb_i(a_stb_i)
     ,.sel_i(a_sel_i)
     ,.we_i(a_we_i)
     ,.dat_o(a_dat_o)
     ,.ack_o(a_ack_o)
     ,.mem_fwd_header_o(br_fwd_header[0])
     ,.mem_fwd_data_o(br_fwd_data[0])
     ,.mem_fwd_v_o(br_fwd_v[0])
     ,.mem_fwd_ready_and_i(br_fwd_ready_and[0])
     ,.mem_rev_header_i(br_rev_header[0])
     ,.mem_rev_data_i(br_rev_data[0])
     ,.mem_rev_v_i(br_rev_v[0])
     ,.mem_rev_ready_and_o(br_rev_ready_and[0])
     );

  wb_client_bridge
   #(.src_id_p(1'b1))
   bridge_b
    (.clk_i(clk_i)
     ,.reset_i(reset_i)
     ,.adr_i(b_adr_i)
     ,.dat_i(b_dat_i)
     ,.cyc_i(b_cyc_i)
     ,.stb_i(b_stb_i)
     ,.sel_i(b_sel_i)
     ,.we_i(b_we_i)
     ,.dat_o(b_dat_o)
     ,.ack_o(b_ack_o)
     ,.mem_fwd_header_o(br_fwd_header[1])
     ,.mem_fwd_data_o(br_fwd_data[1])
     ,.mem_fwd_v_o(br_fwd_v[1])
     ,.mem_fwd_ready_and_i(br_fwd_ready_and[1])
     ,.mem_rev_header_i(br_rev_header[1])
     ,.mem_rev_data_i(br_rev_data[1])
     ,.mem_rev_v_i(br_rev_v[1])
     ,.mem_rev_ready_and_o(br_rev_ready_and[1])
     );

  mem_fwd_arbiter
   arbiter
    (.clk_i(clk_i)
     ,.reset_i(reset_i)
     ,.bridge_fwd_header_i(br_fwd_header)
     ,.bridge_fwd_data_i(br_fwd_data)
     ,.bridge_fwd_v_i(br_fwd_v)
     ,.bridge_fwd_ready_and_o(br_fwd_ready_and)
     ,.bridge_rev_header_o(br_rev_header)
     ,.bridge_rev_data_o(br_rev_data)
     ,.bridge_rev_v_o(br_rev_v)
     ,.bridge_rev_ready_and_i(br_rev_ready_and)
     ,.mem_fwd_header_o(mem_fwd_header)
     ,.mem_fwd_data_o(mem_fwd_data)
     ,.mem_fwd_v_o(mem_fwd_v)
     ,.mem_fwd_ready_and_i(mem_fwd_ready_and)
     ,.mem_rev_header_i(mem_rev_header)
     ,.mem_rev_data_i(mem_rev_data)
     ,.mem_rev_v_i(mem_rev_v)
     ,.mem_rev_ready_and_o(mem_rev_ready_and)
     );

  uc_mem_endpoint
   endpoint
    (.clk_i(clk_i)
     ,.reset_i(reset_i)
     ,.mem_fwd_header_i(mem_fwd_header)
     ,.mem_fwd_data_i(mem_fwd_data)
     ,.mem_fwd_v_i(mem_fwd_v)
     ,.mem_fwd_ready_and_o(mem_fwd_ready_and)
     ,.mem_rev_header_o(mem_rev_header)
     ,.mem_rev_data_o(mem_rev_data)
     ,.mem_rev_v_o(mem_rev_v)
     ,.mem_rev_ready_and_i(mem_rev_ready_and)
     );

endmodule

/* tests/tb_dual_wb_mem.sv */
// Dual Wishbone memory testbench

`timescale 1ns/1ps

`include "wbmem_consts.svh"

module tb_dual_wb_mem;

  localparam int clk_period_ns = 20;
  localparam int reset_cycles = 16;
  localparam int ack_wait_limit = 40;
  localparam int num_random = 200;
  localparam int fill_words = 64;
  // directed tests, region fill and random mix
  localparam int num_accesses = 2 + 12 + 2 + 2 + fill_words + num_random;
  localparam int watchdog_ns = num_accesses * 40 * clk_period_ns
                               + reset_cycles * clk_period_ns;

  typedef struct packed
  {
    logic                we;
    logic [1:0]          gap;
    wbmem_pkg::wb_sel_t  sel;
    wbmem_pkg::wb_adr_t  adr;
    wbmem_pkg::wb_data_t dat;
  } rand_op_s;

  logic clk;
  logic reset;
  logic reset_q = 1'b0;

  wbmem_pkg::wb_adr_t  a_adr;
  wbmem_pkg::wb_data_t a_dat_w;
  logic                a_cyc;
  logic                a_stb;
  wbmem_pkg::wb_sel_t  a_sel;
  logic                a_we;
  wbmem_pkg::wb_data_t a_dat_r;
  logic                a_ack;

  wbmem_pkg::wb_adr_t  b_adr;
  wbmem_pkg::wb_data_t b_dat_w;
  logic                b_cyc;
  logic                b_stb;
  wbmem_pkg::wb_sel_t  b_sel;
  logic                b_we;
  wbmem_pkg::wb_data_t b_dat_r;
  logic                b_ack;

  wbmem_pkg::wb_data_t model_mem [`MEM_WORDS];
  rand_op_s            ops [num_random];
  integer              seed;
  int                  errors = 0;
  int                  test_err_start = 0;
  int                  tests_run = 0;
  int                  tests_ok = 0;
  int                  access_count [2];
  int                  ack_count [2];

  dual_wb_mem_top dut
    (.clk_i(clk)
     ,.reset_i(reset)
     ,.a_adr_i(a_adr)
     ,.a_dat_i(a_dat_w)
     ,.a_cyc_i(a_cyc)
     ,.a_stb_i(a_stb)
     ,.a_sel_i(a_sel)
     ,.a_we_i(a_we)
     ,.a_dat_o(a_dat_r)
     ,.a_ack_o(a_ack)
     ,.b_adr_i(b_adr)
     ,.b_dat_i(b_dat_w)
     ,.b_cyc_i(b_cyc)
     ,.b_stb_i(b_stb)
     ,.b_sel_i(b_sel)
     ,.b_we_i(b_we)
     ,.b_dat_o(b_dat_r)
     ,.b_ack_o(b_ack)
     );

  initial
    begin
      clk = 1'b0;
      forever #(clk_period_ns / 2) clk = ~clk;
    end

  always @(posedge clk)
    reset_q <= reset;

  // acks seen per port
  always @(posedge clk)
    begin
      if (!reset)
        begin
          if (a_ack)
            ack_count[0]++;
          if (b_ack)
            ack_count[1]++;
        end
    end

  a_ack_in_cycle: assert property (@(posedge clk) disable iff (reset) a_ack |-> (a_cyc && a_stb))
  else
    begin
      $display("port a raised ack outside an active cycle");
      errors++;
    end

  b_ack_in_cycle: assert property (@(posedge clk) disable iff (reset) b_ack |-> (b_cyc && b_stb))
  else
    begin
      $display("port b raised ack outside an active cycle");
      errors++;
    end

  a_ack_pulse: assert property (@(posedge clk) disable iff (reset) a_ack |=> !a_ack)
  else
    begin
      $display("port a held ack longer than one cycle");
      errors++;
    end

  b_ack_pulse: assert property (@(posedge clk) disable iff (reset) b_ack |=> !b_ack)
  else
    begin
      $display("port b held ack longer than one cycle");
      errors++;
    end

  ack_in_reset: assert property (@(posedge clk) (reset && reset_q) |-> (!a_ack && !b_ack))
  else
    begin
      $display("ack was high while reset was asserted");
      errors++;
    end

  // byte count for a select code
  function automatic int sel_bytes(wbmem_pkg::wb_sel_t sel);
    int n;
    case (sel)
      8'h01:   n = 1;
      8'h03:   n = 2;
      8'h0F:   n = 4;
      default: n = 8;
    endcase
    return n;
  endfunction

  function automatic wbmem_pkg::wb_data_t low_mask(int nbytes);
    wbmem_pkg::wb_data_t m;
    m = '0;
    for (int i = 0; i < nbytes; i++)
      m[8*i+:8] = 8'hFF;
    return m;
  endfunction

  function automatic wbmem_pkg::wb_data_t spread_bytes(wbmem_pkg::wb_data_t d, int nbytes);
    wbmem_pkg::wb_data_t r;
    for (int i = 0; i < 8; i++)
      r[8*i+:8] = d[8*(i % nbytes)+:8];
    return r;
  endfunction

  function automatic wbmem_pkg::wb_data_t expected_read(wbmem_pkg::wb_adr_t adr,
                                                        wbmem_pkg::wb_sel_t sel);
    return spread_bytes(model_mem[adr], sel_bytes(sel));
  endfunction

  // pattern built from every address bit
  function automatic wbmem_pkg::wb_data_t fill_word(wbmem_pkg::wb_adr_t adr);
    return {6'd0, adr, 16'hF11E, 6'd0, ~adr, 16'h5EED};
  endfunction

  task automatic set_port(input int port, input logic active, input wbmem_pkg::wb_adr_t adr,
                          input wbmem_pkg::wb_data_t wdata, input wbmem_pkg::wb_sel_t sel,
                          input logic we);
    if (port == 0)
      begin
        a_adr <= adr;
        a_dat_w <= wdata;
        a_sel <= sel;
        a_we <= we;
        a_cyc <= active;
        a_stb <= active;
      end
    else
      begin
        b_adr <= adr;
        b_dat_w <= wdata;
        b_sel <= sel;
        b_we <= we;
        b_cyc <= active;
        b_stb <= active;
      end
  endtask

  // starts and ends just after a rising edge
  task automatic wb_access(input int port, input wbmem_pkg::wb_adr_t adr,
                           input wbmem_pkg::wb_data_t wdata, input wbmem_pkg::wb_sel_t sel,
                           input logic we, output wbmem_pkg::wb_data_t rdata, output int lat);
    logic acked;
    acked = 1'b0;
    lat = 0;
    rdata = '0;
    access_count[port]++;
    set_port(port, 1'b1, adr, wdata, sel, we);
    while (!acked && lat < ack_wait_limit)
      begin
        @(posedge clk);
        lat++;
        acked = (port == 0) ? a_ack : b_ack;
        rdata = (port == 0) ? a_dat_r : b_dat_r;
      end
    set_port(port, 1'b0, adr, wdata, sel, we);
    if (!acked)
      begin
        $display("port %0d got no ack within %0d cycles at address %h", port, lat, adr);
        errors++;
      end
    // stb stays low for one cycle between accesses
    @(posedge clk);
  endtask

  task automatic check_value(input string sig, input wbmem_pkg::wb_data_t got,
                             input wbmem_pkg::wb_data_t exp);
    assert (got === exp)
    else
      begin
        $display("mismatch %s: got %h, expected %h", sig, got, exp);
        errors++;
      end
  endtask

  task automatic do_write(input int port, input wbmem_pkg::wb_adr_t adr,
                          input wbmem_pkg::wb_data_t wdata, input wbmem_pkg::wb_sel_t sel,
                          output int lat);
    wbmem_pkg::wb_data_t rdata;
    wbmem_pkg::wb_data_t mask;
    wb_access(port, adr, wdata, sel, 1'b1, rdata, lat);
    mask = low_mask(sel_bytes(sel));
    model_mem[adr] = (model_mem[adr] & ~mask) | (wdata & mask);
  endtask

  task automatic do_read(input int port, input wbmem_pkg::wb_adr_t adr,
                         input wbmem_pkg::wb_sel_t sel, output wbmem_pkg::wb_data_t rdata,
                         output int lat);
    wb_access(port, adr, '0, sel, 1'b0, rdata, lat);
    check_value((port == 0) ? "a_dat_o" : "b_dat_o", rdata, expected_read(adr, sel));
  endtask

  task automatic run_random(input int port);
    wbmem_pkg::wb_data_t rdata;
    int lat;
    for (int k = port; k < num_random; k += 2)
      begin
        repeat (ops[k].gap) @(posedge clk);
        if (ops[k].we)
          do_write(port, ops[k].adr, ops[k].dat, ops[k].sel, lat);
        else
          do_read(port, ops[k].adr, ops[k].sel, rdata, lat);
      end
  endtask

  task automatic check_latency(input string what, input int lat);
    assert (lat == 3)
    else
      begin
        $display("%s took %0d cycles to ack instead of 3", what, lat);
        errors++;
      end
  endtask

  task automatic end_test(input string name);
    tests_run++;
    if (errors == test_err_start)
      begin
        tests_ok++;
        $display("test %0d %s: pass", tests_run, name);
      end
    else
      $display("test %0d %s: FAIL with %0d errors", tests_run, name, errors - test_err_start);
    test_err_start = errors;
  endtask

  // stop a hung run
  initial
    begin
      #(watchdog_ns);
      $display("timeout: the run did not finish within %0d ns", watchdog_ns);
      $display("tests failed");
      $finish;
    end

  initial
    begin
      wbmem_pkg::wb_data_t rdata;
      wbmem_pkg::wb_data_t rdata_b;
      wbmem_pkg::wb_adr_t  adr;
      logic [31:0]         rnd;
      int                  lat;
      int                  lat_b;
      seed = 32'he310_5e98;
      access_count[0] = 0;
      access_count[1] = 0;
      ack_count[0] = 0;
      ack_count[1] = 0;
      reset = 1'b1;
      a_adr = '0;
      a_dat_w = '0;
      a_cyc = 1'b0;
      a_stb = 1'b0;
      a_sel = '0;
      a_we = 1'b0;
      b_adr = '0;
      b_dat_w = '0;
      b_cyc = 1'b0;
      b_stb = 1'b0;
      b_sel = '0;
      b_we = 1'b0;

      // read requests on both ports while reset is held
      repeat (4) @(posedge clk);
      set_port(0, 1'b1, 10'h001, '0, 8'hFF, 1'b0);
      set_port(1, 1'b1, 10'h002, '0, 8'hFF, 1'b0);
      repeat (8) @(posedge clk);
      set_port(0, 1'b0, 10'h001, '0, 8'hFF, 1'b0);
      set_port(1, 1'b0, 10'h002, '0, 8'hFF, 1'b0);
      repeat (reset_cycles - 12) @(posedge clk);
      reset <= 1'b0;

      // idle ports followed by one write and one read
      for (int i = 0; i < 8; i++)
        begin
          @(posedge clk);
          assert (!a_ack && !b_ack)
          else
            begin
              $display("ack raised with no request pending");
              errors++;
            end
        end
      do_write(0, 10'h010, 64'h0123_4567_89AB_CDEF, 8'hFF, lat);
      check_latency("port a write", lat);
      do_read(0, 10'h010, 8'hFF, rdata, lat);
      check_latency("port a read", lat);
      end_test("single write and read");

      do_write(0, 10'h020, 64'h1122_3344_5566_7788, 8'hFF, lat);
      do_write(0, 10'h021, 64'h1122_3344_5566_7788, 8'hFF, lat);
      do_write(0, 10'h022, 64'h1122_3344_5566_7788, 8'hFF, lat);
      do_write(0, 10'h020, 64'hFFFF_FFFF_FFFF_FFAA, 8'h01, lat);
      do_write(0, 10'h021, 64'hFFFF_FFFF_FFFF_BBCC, 8'h03, lat);
      do_write(0, 10'h022, 64'hFFFF_FFFF_DDEE_0099, 8'h0F, lat);
      do_read(0, 10'h020, 8'hFF, rdata, lat);
      check_value("a_dat_o", rdata, 64'h1122_3344_5566_77AA);
      do_read(0, 10'h021, 8'hFF, rdata, lat);
      check_value("a_dat_o", rdata, 64'h1122_3344_5566_BBCC);
      do_read(0, 10'h022, 8'hFF, rdata, lat);
      check_value("a_dat_o", rdata, 64'h1122_3344_DDEE_0099);
      do_read(0, 10'h022, 8'h01, rdata, lat);
      do_read(0, 10'h022, 8'h03, rdata, lat);
      do_read(0, 10'h022, 8'h0F, rdata, lat);
      end_test("sized writes and reads");

      // both ports start on the same edge
      fork
        do_read(0, 10'h020, 8'hFF, rdata, lat);
        do_read(1, 10'h021, 8'hFF, rdata_b, lat_b);
      join
      assert ((lat == 3 || lat_b == 3) && lat != lat_b)
      else
        begin
          $display("concurrent accesses acked after %0d and %0d cycles", lat, lat_b);
          errors++;
        end
      end_test("concurrent ports");

      do_write(1, 10'h030, 64'hCAFE_F00D_1234_5678, 8'hFF, lat);
      do_read(0, 10'h030, 8'hFF, rdata, lat);
      check_value("a_dat_o", rdata, 64'hCAFE_F00D_1234_5678);
      end_test("shared memory");

      // port a owns 0x100 to 0x11f and port b owns 0x120 to 0x13f
      for (int w = 0; w < fill_words; w++)
        begin
          adr = {4'h4, w[5:0]};
          do_write(0, adr, fill_word(adr), 8'hFF, lat);
        end
      for (int k = 0; k < num_random; k++)
        begin
          rnd = $random(seed);
          ops[k].we = rnd[0];
          ops[k].gap = rnd[2:1];
          case (rnd[5:3])
            3'd0:    ops[k].sel = 8'h01;
            3'd1:    ops[k].sel = 8'h03;
            3'd2:    ops[k].sel = 8'h0F;
            3'd3:    ops[k].sel = 8'hFF;
            default: ops[k].sel = rnd[15:8];
          endcase
          ops[k].adr = {4'h4, k[0], rnd[20:16]};
          rnd = $random(seed);
          ops[k].dat[31:0] = rnd;
          rnd = $random(seed);
          ops[k].dat[63:32] = rnd;
        end
      fork
        run_random(0);
        run_random(1);
      join
      for (int p = 0; p < 2; p++)
        begin
          assert (ack_count[p] == access_count[p])
          else
            begin
              $display("port %0d saw %0d acks for %0d accesses", p, ack_count[p],
                       access_count[p]);
              errors++;
            end
        end
      end_test("random mix");

      $display("%0d tests run, %0d passed, %0d errors", tests_run, tests_ok, errors);
      if (errors == 0 && tests_ok == tests_run)
        $display("all tests passed");
      else
        $display("tests failed");
      $finish;
    end

endmodule

/* verilog.f */
+incdir+design
design/wbmem_pkg.sv
design/wb_client_bridge.sv
design/mem_fwd_arbiter.sv
design/uc_mem_endpoint.sv
design/dual_wb_mem_top.sv
tests/tb_dual_wb_mem.sv

/* run_sim.sh */
#!/bin/sh
# build the testbench with Verilator, run it and scan the log

cd "$(dirname "$0")" || exit 1

build_dir=obj_dir
log_file=sim.log
fail_text="tests failed"

verilator --binary --timing --assert \
  -f verilog.f \
  --top-module tb_dual_wb_mem \
  -Mdir "$build_dir" \
  -o tb_dual_wb_mem_sim
status=$?
if [ $status -ne 0 ]; then
  echo "verilator build exited with status $status"
  exit 1
fi

"./$build_dir/tb_dual_wb_mem_sim" > "$log_file" 2>&1
status=$?
cat "$log_file"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "$fail_text" "$log_file"; then
  exit 1
fi

exit 0
